//--- source/arcade_params.svh
`ifndef ARCADE_PARAMS_SVH
`define ARCADE_PARAMS_SVH

// ==============================
// ROM download
// ==============================

// loader byte address and SDRAM word address
`define ARC_DL_ADDR_W     25
`define ARC_SDRAM_ADDR_W  23

// sprite ROMs start here in the download image
`define ARC_SPRITE_BASE   25'h0018000

// set in the loader address for the 16-bit CSD ROM
`define ARC_WIDE_ROM_BIT  16
`define ARC_ROM_INDEX     8'h00

// tab key
`define ARC_KEY_VAN       8'h0D

// ==============================
// reset and audio
// ==============================
`define ARC_RESET_CNT_W   16
`define ARC_AUDIO_W       16
`define ARC_CSD_W         10
`define ARC_CSD_SHIFT     5

`endif

//--- source/arcade_pkg.sv
`include "arcade_params.svh"

package arcade_pkg;

	// loader byte address, flat for 8-bit ROMs, split for the 16-bit ROM reorder
	typedef struct packed {
		logic [`ARC_DL_ADDR_W-`ARC_WIDE_ROM_BIT-1:0] upper;
		logic                                        b15;
		logic                                        b14;
		logic [13:0]                                 low;
	} dl_addr_wide_t;

	typedef union packed {
		logic [`ARC_DL_ADDR_W-1:0] flat;
		dl_addr_wide_t             wide;
	} dl_addr_u;

	typedef struct packed {
		logic       active;
		logic       wr;
		logic [7:0] index;
		dl_addr_u   addr;
		logic [7:0] data;
	} dl_write_t;

	// req is a toggle, one inversion per write
	typedef struct packed {
		logic                         req;
		logic [`ARC_SDRAM_ADDR_W-1:0] addr;
		logic [1:0]                   ds;
		logic [15:0]                  data;
	} sdram_wr_t;

	typedef struct packed {
		logic coin2;
		logic coin1;
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
	} player_in_t;

	typedef struct packed {
		logic gun;
		logic missile;
		logic shift_state;
		logic van;
		logic oil;
		logic smoke;
	} cabinet_in_t;

	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef logic [`ARC_AUDIO_W-1:0] audio_t;
	typedef logic [`ARC_CSD_W-1:0]   csd_audio_t;

endpackage

//--- source/sigma_delta_dac.sv
`timescale 1ns/100ps
`include "arcade_params.svh"

module sigma_delta_dac (
	input  logic               clk_sys,
	input  logic               rst_n_i,
	input  arcade_pkg::audio_t sample_i,
	output logic               bit_o
);

	logic [`ARC_AUDIO_W:0] acc_d;
	logic [`ARC_AUDIO_W:0] acc_q;

	// residue plus new sample, carry out is the pulse
	assign acc_d = {1'b0, acc_q[`ARC_AUDIO_W-1:0]} + {1'b0, sample_i};

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i)
			acc_q <= '0;
		else
			acc_q <= acc_d;
	end

	// pulse density tracks sample / 2^16
	assign bit_o = acc_q[`ARC_AUDIO_W];

endmodule

//--- source/audio_mixer.sv
`timescale 1ns/100ps
`include "arcade_params.svh"

module audio_mixer (
	input  logic                   clk_sys,
	input  logic                   rst_n_i,
	input  arcade_pkg::audio_t     audio_l_i,
	input  arcade_pkg::audio_t     audio_r_i,
	input  arcade_pkg::csd_audio_t csd_audio_i,
	output logic                   dac_l_o,
	output logic                   dac_r_o
);

	logic [`ARC_AUDIO_W:0] csd_scaled;
	logic [`ARC_AUDIO_W:0] sum_l;
	logic [`ARC_AUDIO_W:0] sum_r;

	// sound board output sits below the core's full scale
	assign csd_scaled = {{(`ARC_AUDIO_W + 1 - `ARC_CSD_W){1'b0}}, csd_audio_i} << `ARC_CSD_SHIFT;
	assign sum_l      = {1'b0, audio_l_i} + csd_scaled;
	assign sum_r      = {1'b0, audio_r_i} + csd_scaled;

	// drop the lsb so the carry fits
	sigma_delta_dac u_dac_l (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.sample_i (sum_l[`ARC_AUDIO_W:1]),
		.bit_o    (dac_l_o)
	);

	sigma_delta_dac u_dac_r (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.sample_i (sum_r[`ARC_AUDIO_W:1]),
		.bit_o    (dac_r_o)
	);

endmodule

//--- source/rom_loader.sv
`timescale 1ns/100ps
`include "arcade_params.svh"

module rom_loader (
	input  logic                  clk_sys,
	input  logic                  rst_n_i,
	input  arcade_pkg::dl_write_t dl_i,
	output arcade_pkg::sdram_wr_t port_cpu_o,
	output arcade_pkg::sdram_wr_t port_sprite_o,
	output logic                  rom_loaded_o
);

	logic                         wr_last_q;
	logic                         write_edge;
	arcade_pkg::dl_addr_u         rom_addr;
	logic [`ARC_DL_ADDR_W-1:0]    sp_addr;
	logic                         cpu_req_q;
	logic                         sprite_req_q;
	logic [`ARC_SDRAM_ADDR_W-1:0] cpu_addr_q;
	logic [`ARC_SDRAM_ADDR_W-1:0] sprite_addr_q;
	logic [1:0]                   cpu_ds_q;
	logic [1:0]                   sprite_ds_q;
	logic [15:0]                  data_q;
	logic                         active_q;
	logic                         end_q;
	logic                         loaded_q;

	// one byte per rising edge of the loader strobe
	assign write_edge = dl_i.active && dl_i.wr && !wr_last_q && (dl_i.index == `ARC_ROM_INDEX);

	// bit 14 moves down to select the byte in the 16-bit CSD ROM
	always_comb begin
		rom_addr = dl_i.addr;
		if (dl_i.addr.flat[`ARC_WIDE_ROM_BIT])
			rom_addr.flat = {dl_i.addr.wide.upper, dl_i.addr.wide.b15,
				dl_i.addr.wide.low, dl_i.addr.wide.b14};
	end

	assign sp_addr = dl_i.addr.flat - `ARC_SPRITE_BASE;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_last_q    <= 1'b0;
			cpu_req_q    <= 1'b0;
			sprite_req_q <= 1'b0;
			active_q     <= 1'b0;
			end_q        <= 1'b0;
			loaded_q     <= 1'b0;
		end else begin
			wr_last_q <= dl_i.wr;
			active_q  <= dl_i.active;
			end_q     <= active_q & ~dl_i.active;
			// sticky once the first download has finished
			if (end_q)
				loaded_q <= 1'b1;
			if (write_edge) begin
				cpu_req_q    <= ~cpu_req_q;
				sprite_req_q <= ~sprite_req_q;
			end
		end
	end

	// sprite bytes interleave into 32-bit words over two 16-bit halves
	always_ff @(posedge clk_sys) begin
		if (write_edge) begin
			cpu_addr_q    <= rom_addr.flat[`ARC_SDRAM_ADDR_W:1];
			cpu_ds_q      <= {rom_addr.flat[0], ~rom_addr.flat[0]};
			sprite_addr_q <= {sp_addr[23:17], sp_addr[14:0], sp_addr[16]};
			sprite_ds_q   <= {sp_addr[15], ~sp_addr[15]};
			data_q        <= {2{dl_i.data}};
		end
	end

	assign port_cpu_o    = '{req: cpu_req_q, addr: cpu_addr_q, ds: cpu_ds_q, data: data_q};
	assign port_sprite_o = '{req: sprite_req_q, addr: sprite_addr_q, ds: sprite_ds_q, data: data_q};
	assign rom_loaded_o  = loaded_q;

	// the loader strobes bytes only while a download is active
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		dl_i.wr |-> dl_i.active);

endmodule

//--- source/reset_sequencer.sv
`timescale 1ns/100ps
`include "arcade_params.svh"

module reset_sequencer (
	input  logic clk_sys,
	input  logic rst_n_i,
	input  logic menu_reset_i,
	input  logic button_reset_i,
	input  logic rom_loaded_i,
	output logic game_reset_o
);

	logic                        cause;
	logic [`ARC_RESET_CNT_W-1:0] count_q;
	logic                        reset_q;

	assign cause = menu_reset_i | button_reset_i | ~rom_loaded_i;

	// the core wants a second reset pulse after the first release
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q <= '1;
			reset_q <= 1'b1;
		end else begin
			if (cause)
				count_q <= '1;
			else if (count_q != '0)
				count_q <= count_q - 1'b1;
			reset_q <= cause | (count_q == `ARC_RESET_CNT_W'(1));
		end
	end

	assign game_reset_o = reset_q;

	// a complete ROM image stays loaded
	a_loaded_sticky: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		rom_loaded_i |=> rom_loaded_i);

endmodule

//--- source/player_controls.sv
`timescale 1ns/100ps
`include "arcade_params.svh"

module player_controls (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  arcade_pkg::player_in_t  buttons_i,
	input  arcade_pkg::key_event_t  key_i,
	output arcade_pkg::cabinet_in_t cabinet_o
);

	logic fire_c_q;
	logic shift_q;
	logic van_key_q;

	// ==============================
	// gearbox and van latch
	// ==============================
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fire_c_q  <= 1'b0;
			shift_q   <= 1'b0;
			van_key_q <= 1'b0;
		end else begin
			fire_c_q <= buttons_i.fire_c;
			// a coin drops back into low gear
			if (buttons_i.coin1 | buttons_i.coin2)
				shift_q <= 1'b0;
			else if (buttons_i.fire_c & ~fire_c_q)
				shift_q <= ~shift_q;
			if (key_i.strobe && (key_i.code == `ARC_KEY_VAN))
				van_key_q <= key_i.pressed;
		end
	end

	assign cabinet_o = '{
		gun:         buttons_i.fire_a,
		missile:     buttons_i.fire_b,
		shift_state: shift_q,
		van:         van_key_q | buttons_i.fire_d,
		oil:         buttons_i.fire_e,
		smoke:       buttons_i.fire_f
	};

endmodule

//--- source/arcade_top.sv
`timescale 1ns/100ps

module arcade_top (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  arcade_pkg::dl_write_t   dl_i,
	input  logic                    menu_reset_i,
	input  logic                    button_reset_i,
	input  arcade_pkg::player_in_t  buttons_i,
	input  arcade_pkg::key_event_t  key_i,
	input  arcade_pkg::audio_t      audio_l_i,
	input  arcade_pkg::audio_t      audio_r_i,
	input  arcade_pkg::csd_audio_t  csd_audio_i,
	output arcade_pkg::sdram_wr_t   port_cpu_o,
	output arcade_pkg::sdram_wr_t   port_sprite_o,
	output logic                    game_reset_o,
	output arcade_pkg::cabinet_in_t cabinet_o,
	output logic                    audio_l_o,
	output logic                    audio_r_o
);

	logic rom_loaded;

	// ==============================
	// ROM download and reset
	// ==============================
	rom_loader u_rom_loader (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.dl_i          (dl_i),
		.port_cpu_o    (port_cpu_o),
		.port_sprite_o (port_sprite_o),
		.rom_loaded_o  (rom_loaded)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.menu_reset_i   (menu_reset_i),
		.button_reset_i (button_reset_i),
		.rom_loaded_i   (rom_loaded),
		.game_reset_o   (game_reset_o)
	);

	// ==============================
	// controls and audio
	// ==============================
	player_controls u_player_controls (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.buttons_i (buttons_i),
		.key_i     (key_i),
		.cabinet_o (cabinet_o)
	);

	audio_mixer u_audio_mixer (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.audio_l_i   (audio_l_i),
		.audio_r_i   (audio_r_i),
		.csd_audio_i (csd_audio_i),
		.dac_l_o     (audio_l_o),
		.dac_r_o     (audio_r_o)
	);

endmodule

//--- bench/arcade_tb.sv
`timescale 1ns/100ps
`include "arcade_params.svh"

module arcade_tb;

	logic                    clk_sys;
	logic                    rst_n_i;
	arcade_pkg::dl_write_t   dl;
	logic                    menu_reset;
	logic                    button_reset;
	arcade_pkg::player_in_t  buttons;
	arcade_pkg::key_event_t  key;
	arcade_pkg::audio_t      audio_l;
	arcade_pkg::audio_t      audio_r;
	arcade_pkg::csd_audio_t  csd_audio;
	arcade_pkg::sdram_wr_t   port_cpu;
	arcade_pkg::sdram_wr_t   port_sprite;
	logic                    game_reset;
	arcade_pkg::cabinet_in_t cabinet;
	logic                    dac_l;
	logic                    dac_r;

	// reference model state
	logic        m_wr_last, m_req, m_written, m_active, m_end, m_loaded;
	logic        m_reset, m_fire_c, m_shift, m_van;
	logic [15:0] m_count;
	logic [16:0] m_acc_l, m_acc_r;
	logic [22:0] m_cpu_addr, m_sp_addr;
	logic [1:0]  m_cpu_ds, m_sp_ds;
	logic [15:0] m_data;
	int          check_count;
	int          error_count;

	arcade_top u_arcade_top (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.dl_i           (dl),
		.menu_reset_i   (menu_reset),
		.button_reset_i (button_reset),
		.buttons_i      (buttons),
		.key_i          (key),
		.audio_l_i      (audio_l),
		.audio_r_i      (audio_r),
		.csd_audio_i    (csd_audio),
		.port_cpu_o     (port_cpu),
		.port_sprite_o  (port_sprite),
		.game_reset_o   (game_reset),
		.cabinet_o      (cabinet),
		.audio_l_o      (dac_l),
		.audio_r_o      (dac_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s: got %0h, expected %0h at %0t", name, actual, expected, $time);
		end
	endtask

	// ==============================
	// reference model
	// ==============================
	task automatic model_step();
		logic        cause;
		logic [24:0] a;
		logic [24:0] s;
		logic [16:0] csd_w;
		logic [16:0] sum_l;
		logic [16:0] sum_r;
		cause = menu_reset | button_reset | ~m_loaded;
		m_reset = cause | (m_count == 16'd1);
		if (cause)
			m_count = '1;
		else if (m_count != 16'd0)
			m_count = m_count - 16'd1;
		// loaded flag lags the end of download by two edges
		if (m_end)
			m_loaded = 1'b1;
		m_end = m_active & ~dl.active;
		m_active = dl.active;
		if (dl.active && dl.wr && !m_wr_last && dl.index == `ARC_ROM_INDEX) begin
			a = dl.addr.flat;
			if (a[16])
				a = {a[24:16], a[15], a[13:0], a[14]};
			s = dl.addr.flat - `ARC_SPRITE_BASE;
			m_req = ~m_req;
			m_written = 1'b1;
			m_cpu_addr = a[23:1];
			m_cpu_ds = {a[0], ~a[0]};
			m_sp_addr = {s[23:17], s[14:0], s[16]};
			m_sp_ds = {s[15], ~s[15]};
			m_data = {dl.data, dl.data};
		end
		m_wr_last = dl.wr;
		if (buttons.coin1 | buttons.coin2)
			m_shift = 1'b0;
		else if (buttons.fire_c && !m_fire_c)
			m_shift = ~m_shift;
		m_fire_c = buttons.fire_c;
		if (key.strobe && key.code == `ARC_KEY_VAN)
			m_van = key.pressed;
		csd_w = 17'(csd_audio) << `ARC_CSD_SHIFT;
		sum_l = {1'b0, audio_l} + csd_w;
		sum_r = {1'b0, audio_r} + csd_w;
		m_acc_l = {1'b0, m_acc_l[15:0]} + {1'b0, sum_l[16:1]};
		m_acc_r = {1'b0, m_acc_r[15:0]} + {1'b0, sum_r[16:1]};
	endtask

	always @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			{m_wr_last, m_req, m_written, m_active, m_end, m_loaded} = '0;
			{m_fire_c, m_shift, m_van} = '0;
			m_reset = 1'b1;
			m_count = '1;
			m_acc_l = '0;
			m_acc_r = '0;
		end else begin
			model_step();
		end
	end

	// outputs are compared in the middle of the cycle
	always @(negedge clk_sys) begin
		if (rst_n_i) begin
			check_value("port_cpu_o.req", port_cpu.req, m_req);
			check_value("port_sprite_o.req", port_sprite.req, m_req);
			if (m_written) begin
				check_value("port_cpu_o.addr", port_cpu.addr, m_cpu_addr);
				check_value("port_cpu_o.ds", port_cpu.ds, m_cpu_ds);
				check_value("port_cpu_o.data", port_cpu.data, m_data);
				check_value("port_sprite_o.addr", port_sprite.addr, m_sp_addr);
				check_value("port_sprite_o.ds", port_sprite.ds, m_sp_ds);
				check_value("port_sprite_o.data", port_sprite.data, m_data);
			end
			check_value("game_reset_o", game_reset, m_reset);
			check_value("cabinet_o", cabinet, {buttons.fire_a, buttons.fire_b, m_shift,
				m_van | buttons.fire_d, buttons.fire_e, buttons.fire_f});
			check_value("audio_l_o", dac_l, m_acc_l[16]);
			check_value("audio_r_o", dac_r, m_acc_r[16]);
		end
	end

	// ==============================
	// stimulus
	// ==============================
	task automatic drive_controls();
		arcade_pkg::player_in_t b;
		arcade_pkg::key_event_t k;
		b = 8'($urandom);
		// coins are rare so the gearbox gets to toggle
		if ($urandom_range(15) != 0) begin
			b.coin1 = 1'b0;
			b.coin2 = 1'b0;
		end
		k.strobe = ($urandom_range(3) == 0);
		k.pressed = 1'($urandom);
		k.code = ($urandom_range(1) != 0) ? `ARC_KEY_VAN : 8'($urandom);
		buttons <= b;
		key <= k;
		audio_l <= 16'($urandom);
		audio_r <= 16'($urandom);
		csd_audio <= 10'($urandom);
	endtask

	task automatic tick();
		@(posedge clk_sys);
		drive_controls();
	endtask

	task automatic rom_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		tick();
		dl.index <= index;
		dl.addr.flat <= addr;
		dl.data <= data;
		dl.wr <= 1'b1;
		tick();
		dl.wr <= 1'b0;
		tick();
	endtask

	task automatic wait_game_reset(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (game_reset !== level && n < limit) begin
			tick();
			@(negedge clk_sys);
			n++;
		end
		if (game_reset !== level) begin
			error_count++;
			$display("timeout after %0d cycles waiting for %s", limit, what);
		end
	endtask

	initial begin
		logic [24:0] addr;
		logic [7:0]  index;
		void'($urandom(32'h91769e4e));
		check_count = 0;
		error_count = 0;
		rst_n_i = 1'b0;
		dl = '0;
		menu_reset = 1'b0;
		button_reset = 1'b0;
		buttons = '0;
		key = '0;
		audio_l = '0;
		audio_r = '0;
		csd_audio = '0;
		repeat (5) @(posedge clk_sys);
		rst_n_i <= 1'b1;
		tick();
		dl.active <= 1'b1;
		for (int i = 0; i < 300; i++) begin
			case ($urandom_range(2))
				0: addr = 25'($urandom_range(32'h0FFFF));
				1: addr = 25'h10000 + 25'($urandom_range(32'h7FFF));
				default: addr = `ARC_SPRITE_BASE + 25'($urandom_range(32'h3FFFF));
			endcase
			index = ($urandom_range(3) == 0) ? 8'($urandom_range(255, 1)) : `ARC_ROM_INDEX;
			rom_write(index, addr, 8'($urandom));
		end
		tick();
		dl.active <= 1'b0;
		wait_game_reset(1'b0, 20, "release after download");
		wait_game_reset(1'b1, 70000, "delayed reset pulse");
		wait_game_reset(1'b0, 4, "end of delayed reset pulse");
		tick();
		menu_reset <= 1'b1;
		repeat (3) tick();
		menu_reset <= 1'b0;
		wait_game_reset(1'b0, 20, "release after menu reset");
		tick();
		button_reset <= 1'b1;
		repeat (3) tick();
		button_reset <= 1'b0;
		wait_game_reset(1'b0, 20, "release after button reset");
		repeat (500) tick();
		@(negedge clk_sys);
		@(posedge clk_sys);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+source
source/arcade_pkg.sv
source/sigma_delta_dac.sv
source/audio_mixer.sv
source/rom_loader.sv
source/reset_sequencer.sv
source/player_controls.sv
source/arcade_top.sv
bench/arcade_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module arcade_tb \
		-f sources.f -Mdir obj_dir -o arcade_sim

run: compile
	./obj_dir/arcade_sim > sim.log 2>&1; cat sim.log
	@! grep -q "Regression failed" sim.log
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
